// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_a2_card_top
DUT_TOP   ?= a2_card_top
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# Pass only if the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(DUT_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: dv/a2_card_checker.sv
`timescale 1ns/1ps

module a2_card_checker (
    input logic clk_logic_w,
    input logic arst_n_i,
    input logic phi1_i,
    input logic data_oe_i,
    input logic uart_tx_i
);

    logic [4:0] phi1_high_cnt;
    logic [4:0] oe_high_cnt;

    // Saturating run lengths of Phi1 high and of the data enable
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phi1_high_cnt <= '0;
            oe_high_cnt   <= '0;
        end else begin
            if (!phi1_i) begin
                phi1_high_cnt <= '0;
            end else if (phi1_high_cnt != '1) begin
                phi1_high_cnt <= phi1_high_cnt + 1'b1;
            end
            if (!data_oe_i) begin
                oe_high_cnt <= '0;
            end else if (oe_high_cnt != '1) begin
                oe_high_cnt <= oe_high_cnt + 1'b1;
            end
        end
    end

    // Bus released well before Phi1 ends
    assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        (phi1_high_cnt >= 5'd5) |-> !data_oe_i)
        else $error("a2_data_oe_o still high after Phi1 was high for 5 cycles");

    assert property (@(posedge clk_logic_w)
        !arst_n_i |=> uart_tx_i)
        else $error("uart_tx_o low during reset");

    assert property (@(posedge clk_logic_w) disable iff (!arst_n_i)
        oe_high_cnt <= 5'd20)
        else $error("a2_data_oe_o high for more than 20 cycles");

endmodule

bind a2_card_top a2_card_checker u_checker (
    .clk_logic_w (clk_logic_w),
    .arst_n_i    (arst_n_i),
    .phi1_i      (a2_phi1_i),
    .data_oe_i   (a2_data_oe_o),
    .uart_tx_i   (uart_tx_o)
);

// File: dv/tb_a2_card_top.sv
`timescale 1ns/1ps

module tb_a2_card_top;
    import a2_card_pkg::*;

    localparam int TIMER_SLOT  = 4;
    localparam int SERIAL_SLOT = 2;
    localparam int BAUD_DIV    = 16;
    // Clocks per Phi1 half of a bus cycle
    localparam int HALF_CLKS   = 10;
    // Far more than the few dozen bus cycles of the longest test
    localparam int MAX_BUS_CYCLES = 1000;
    localparam int WATCHDOG_CLKS  = MAX_BUS_CYCLES * 2 * HALF_CLKS;

    // Device select page C080 plus 16 addresses per slot
    localparam logic [ADDR_W-1:0] TMR_BASE = 16'(16'hC080 + 16 * TIMER_SLOT);
    localparam logic [ADDR_W-1:0] SER_BASE = 16'(16'hC080 + 16 * SERIAL_SLOT);
    localparam logic [ADDR_W-1:0] TMR_LO   = TMR_BASE | 16'(TMR_REG_LO);
    localparam logic [ADDR_W-1:0] TMR_HI   = TMR_BASE | 16'(TMR_REG_HI);
    localparam logic [ADDR_W-1:0] TMR_CTRL = TMR_BASE | 16'(TMR_REG_CTRL);
    localparam logic [ADDR_W-1:0] TMR_STAT = TMR_BASE | 16'(TMR_REG_STAT);
    localparam logic [ADDR_W-1:0] SER_DATA = SER_BASE | 16'(SER_REG_DATA);
    localparam logic [ADDR_W-1:0] SER_STAT = SER_BASE | 16'(SER_REG_STAT);
    localparam logic [ADDR_W-1:0] SER_CTRL = SER_BASE | 16'(SER_REG_CTRL);

    logic              clk_logic_w;
    logic              arst_n_i;
    logic              a2_phi1_i;
    logic [ADDR_W-1:0] a2_addr_i;
    logic              a2_rw_n_i;
    logic [DATA_W-1:0] a2_data_i;
    logic [DATA_W-1:0] a2_data_o;
    logic              a2_data_oe_o;
    logic              a2_irq_n_o;
    logic              uart_tx_o;

    int   err_count;
    int   test_count;
    int   failed_tests;
    // IRQ line as seen late in the last bus cycle
    logic irq_n_s;

    a2_card_top #(
        .TIMER_SLOT  (TIMER_SLOT),
        .SERIAL_SLOT (SERIAL_SLOT),
        .BAUD_DIV    (BAUD_DIV)
    ) u_dut (
        .clk_logic_w  (clk_logic_w),
        .arst_n_i     (arst_n_i),
        .a2_phi1_i    (a2_phi1_i),
        .a2_addr_i    (a2_addr_i),
        .a2_rw_n_i    (a2_rw_n_i),
        .a2_data_i    (a2_data_i),
        .a2_data_o    (a2_data_o),
        .a2_data_oe_o (a2_data_oe_o),
        .a2_irq_n_o   (a2_irq_n_o),
        .uart_tx_o    (uart_tx_o)
    );

    initial begin
        clk_logic_w = 1'b0;
        forever #50 clk_logic_w = ~clk_logic_w;
    end

    task automatic expect_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("error: %s is %h, expected %h", name, got, exp);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int start_errs);
        test_count++;
        if (err_count == start_errs) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, err_count - start_errs);
        end
    endtask

    // One bus cycle entered and left right after a rising clock edge
    task automatic run_cycle(input logic [ADDR_W-1:0] addr, input logic rw_n,
                             input logic [DATA_W-1:0] wdata,
                             output logic [DATA_W-1:0] rdata, output logic oe);
        a2_phi1_i <= 1'b0;
        a2_addr_i <= addr;
        a2_rw_n_i <= rw_n;
        a2_data_i <= wdata;
        repeat (HALF_CLKS - 1) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        rdata = a2_data_o;
        oe    = a2_data_oe_o;
        @(posedge clk_logic_w);
        a2_phi1_i <= 1'b1;
        repeat (HALF_CLKS - 1) @(posedge clk_logic_w);
        @(negedge clk_logic_w);
        irq_n_s = a2_irq_n_o;
        @(posedge clk_logic_w);
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused_data;
        logic              unused_oe;
        run_cycle(addr, 1'b0, data, unused_data, unused_oe);
    endtask

    task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
        logic oe;
        run_cycle(addr, 1'b1, 8'h00, data, oe);
        if (!oe) begin
            $display("read of address %h was not answered, data enable stayed low", addr);
            err_count++;
        end
    endtask

    // Unselected read that still gives the timer one cycle end
    task automatic idle_cycle();
        logic [DATA_W-1:0] unused_data;
        logic              unused_oe;
        run_cycle(16'h0000, 1'b1, 8'h00, unused_data, unused_oe);
    endtask

    task automatic load_timer(input logic [7:0] ctrl, input logic [15:0] value);
        bus_write(TMR_CTRL, ctrl);
        bus_write(TMR_LO, value[7:0]);
        bus_write(TMR_HI, value[15:8]);
    endtask

    task automatic wait_serial_irq();
        int n;
        n = 0;
        while (irq_n_s && n < 20) begin
            idle_cycle();
            n++;
        end
        if (irq_n_s) begin
            $display("serial IRQ never asserted after the frame");
            err_count++;
        end
    endtask

    // Watches the line for one 8N1 frame and samples each bit in its centre
    task automatic check_frame(input logic [7:0] tx_byte);
        int wait_clks;
        wait_clks = 0;
        @(negedge clk_logic_w);
        while (uart_tx_o !== 1'b0 && wait_clks < 4 * HALF_CLKS) begin
            @(negedge clk_logic_w);
            wait_clks++;
        end
        if (uart_tx_o !== 1'b0) begin
            $display("start bit never appeared on uart_tx_o");
            err_count++;
        end else begin
            repeat (BAUD_DIV / 2) @(negedge clk_logic_w);
            expect_eq("uart_tx_o start bit", 8'(uart_tx_o), 8'h00);
            for (int i = 0; i < 8; i++) begin
                repeat (BAUD_DIV) @(negedge clk_logic_w);
                expect_eq("uart_tx_o data bit", 8'(uart_tx_o), 8'(tx_byte[i]));
            end
            repeat (BAUD_DIV) @(negedge clk_logic_w);
            expect_eq("uart_tx_o stop bit", 8'(uart_tx_o), 8'h01);
        end
    endtask

    task automatic test_reset_state();
        int                start_errs;
        logic [DATA_W-1:0] rd;
        logic              oe;
        start_errs = err_count;
        @(negedge clk_logic_w);
        expect_eq("a2_data_oe_o", 8'(a2_data_oe_o), 8'h00);
        expect_eq("a2_irq_n_o", 8'(a2_irq_n_o), 8'h01);
        expect_eq("uart_tx_o", 8'(uart_tx_o), 8'h01);
        @(posedge clk_logic_w);
        // Slot 7 holds no card
        run_cycle(16'hC0F0, 1'b1, 8'h00, rd, oe);
        expect_eq("a2_data_oe_o", 8'(oe), 8'h00);
        report_test("reset_state", start_errs);
    endtask

    task automatic test_timer_irq();
        int                start_errs;
        logic [DATA_W-1:0] rd;
        start_errs = err_count;
        load_timer(8'h01, 16'd5);
        bus_read(TMR_STAT, rd);
        expect_eq("a2_data_o timer STAT", rd, 8'h00);
        expect_eq("a2_irq_n_o", 8'(irq_n_s), 8'h01);
        // STAT read took 5 to 4 and four idles reach 0 so the fifth underflows
        repeat (5) idle_cycle();
        expect_eq("a2_irq_n_o", 8'(irq_n_s), 8'h00);
        bus_read(TMR_STAT, rd);
        expect_eq("a2_data_o timer STAT bit 0", 8'(rd[0]), 8'h01);
        bus_write(TMR_STAT, 8'h00);
        expect_eq("a2_irq_n_o", 8'(irq_n_s), 8'h01);
        report_test("timer_irq", start_errs);
    endtask

    task automatic test_timer_readback();
        int                start_errs;
        int unsigned       k;
        logic [DATA_W-1:0] rd;
        start_errs = err_count;
        k = $urandom_range(9, 2);
        load_timer(8'h00, 16'd100);
        bus_read(TMR_STAT, rd);
        expect_eq("a2_data_o timer STAT", rd, 8'h00);
        repeat (k) idle_cycle();
        bus_read(TMR_LO, rd);
        // One count for the STAT read and one per idle cycle
        expect_eq("a2_data_o timer LO", rd, 8'(100 - k - 1));
        bus_read(TMR_HI, rd);
        expect_eq("a2_data_o timer HI", rd, 8'h00);
        report_test("timer_readback", start_errs);
    endtask

    task automatic test_serial_tx();
        int                start_errs;
        logic [DATA_W-1:0] tx_byte;
        logic [DATA_W-1:0] rd;
        start_errs = err_count;
        tx_byte = 8'($urandom);
        fork
            begin
                bus_write(SER_DATA, tx_byte);
                bus_read(SER_STAT, rd);
                expect_eq("a2_data_o serial STAT", rd, 8'h01);
            end
            check_frame(tx_byte);
        join
        @(posedge clk_logic_w);
        bus_read(SER_DATA, rd);
        expect_eq("a2_data_o serial DATA", rd, tx_byte);
        // Frame is over so done is up and the read clears it
        bus_read(SER_STAT, rd);
        expect_eq("a2_data_o serial STAT", rd, 8'h02);
        report_test("serial_tx", start_errs);
    endtask

    task automatic test_serial_irq();
        int                start_errs;
        logic [DATA_W-1:0] rd;
        start_errs = err_count;
        bus_write(SER_CTRL, 8'h01);
        bus_write(SER_DATA, 8'($urandom));
        wait_serial_irq();
        bus_read(SER_STAT, rd);
        expect_eq("a2_data_o serial STAT", rd, 8'h02);
        expect_eq("a2_irq_n_o", 8'(irq_n_s), 8'h01);
        bus_read(SER_STAT, rd);
        expect_eq("a2_data_o serial STAT", rd, 8'h00);
        report_test("serial_irq", start_errs);
    endtask

    task automatic test_shared_irq();
        int                start_errs;
        logic [DATA_W-1:0] tx_byte;
        logic [DATA_W-1:0] rd;
        start_errs = err_count;
        tx_byte = 8'($urandom);
        bus_write(SER_CTRL, 8'h01);
        bus_write(SER_DATA, tx_byte);
        wait_serial_irq();
        // Count of 2 underflows at the end of the third idle cycle
        load_timer(8'h01, 16'd2);
        repeat (3) idle_cycle();
        // Long reload keeps the timer flag from firing again
        bus_write(TMR_LO, 8'hFF);
        bus_write(TMR_HI, 8'hFF);
        expect_eq("a2_irq_n_o", 8'(irq_n_s), 8'h00);
        bus_read(TMR_STAT, rd);
        expect_eq("a2_data_o timer STAT", rd, 8'h01);
        bus_read(SER_DATA, rd);
        expect_eq("a2_data_o serial DATA", rd, tx_byte);
        bus_read(TMR_HI, rd);
        expect_eq("a2_data_o timer HI", rd, 8'hFF);
        bus_read(SER_STAT, rd);
        expect_eq("a2_data_o serial STAT", rd, 8'h02);
        expect_eq("a2_irq_n_o", 8'(irq_n_s), 8'h00);
        bus_read(TMR_CTRL, rd);
        expect_eq("a2_data_o timer CTRL", rd, 8'h01);
        bus_write(TMR_STAT, 8'h00);
        expect_eq("a2_irq_n_o", 8'(irq_n_s), 8'h01);
        report_test("shared_irq", start_errs);
    endtask

    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk_logic_w);
        $display("watchdog expired after %0d clocks, the run did not finish", WATCHDOG_CLKS);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        arst_n_i     = 1'b0;
        a2_phi1_i    = 1'b1;
        a2_addr_i    = '0;
        a2_rw_n_i    = 1'b1;
        a2_data_i    = '0;
        err_count    = 0;
        test_count   = 0;
        failed_tests = 0;
        irq_n_s      = 1'b1;
        void'($urandom(24));
        repeat (3) @(posedge clk_logic_w);
        arst_n_i <= 1'b1;
        @(posedge clk_logic_w);
        test_reset_state();
        test_timer_irq();
        test_timer_readback();
        test_serial_tx();
        test_serial_irq();
        test_shared_irq();
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
src/a2_card_pkg.sv
src/phi_sync.sv
src/bus_capture.sv
src/timer_card.sv
src/serial_card.sv
src/bus_arbiter.sv
src/a2_card_top.sv
dv/a2_card_checker.sv
dv/tb_a2_card_top.sv

// File: src/a2_card_pkg.sv
package a2_card_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;
    localparam int SLOT_W = 3;
    localparam int REG_W  = 4;

    // High byte of the I/O page, C0xx
    localparam logic [7:0] IO_PAGE = 8'hC0;

    // Timer registers
    localparam logic [REG_W-1:0] TMR_REG_LO   = 4'd0;
    localparam logic [REG_W-1:0] TMR_REG_HI   = 4'd1;
    localparam logic [REG_W-1:0] TMR_REG_CTRL = 4'd2;
    localparam logic [REG_W-1:0] TMR_REG_STAT = 4'd3;

    // Serial registers
    localparam logic [REG_W-1:0] SER_REG_DATA = 4'd0;
    localparam logic [REG_W-1:0] SER_REG_STAT = 4'd1;
    localparam logic [REG_W-1:0] SER_REG_CTRL = 4'd2;

    // Bus address, seen raw or as device-select fields
    // C080 + slot * 16 + reg selects one card register
    typedef union packed {
        logic [ADDR_W-1:0] raw;
        struct packed {
            logic [7:0]        page;
            logic              devsel;
            logic [SLOT_W-1:0] slot;
            logic [REG_W-1:0]  reg_idx;
        } io;
    } a2_addr_u;

endpackage

// File: src/a2_card_top.sv
`timescale 1ns/1ps

module a2_card_top #(
    parameter int TIMER_SLOT  = 4,
    parameter int SERIAL_SLOT = 2,
    parameter int BAUD_DIV    = 16
) (
    input  logic                           clk_logic_w,
    input  logic                           arst_n_i,
    input  logic                           a2_phi1_i,
    input  logic [a2_card_pkg::ADDR_W-1:0] a2_addr_i,
    input  logic                           a2_rw_n_i,
    input  logic [a2_card_pkg::DATA_W-1:0] a2_data_i,
    output logic [a2_card_pkg::DATA_W-1:0] a2_data_o,
    output logic                           a2_data_oe_o,
    output logic                           a2_irq_n_o,
    output logic                           uart_tx_o
);
    import a2_card_pkg::*;

    logic              cycle_start_w;
    logic              cycle_end_w;
    a2_addr_u          addr_w;
    logic              rw_n_w;
    logic              bus_valid_w;
    logic              rd_stb_w;
    logic              wr_stb_w;
    logic [DATA_W-1:0] wr_data_w;
    logic              timer_rd_en_w;
    logic [DATA_W-1:0] timer_rd_data_w;
    logic              timer_irq_n_w;
    logic              serial_rd_en_w;
    logic [DATA_W-1:0] serial_rd_data_w;
    logic              serial_irq_n_w;

    phi_sync u_phi_sync (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .phi1_i        (a2_phi1_i),
        .cycle_start_o (cycle_start_w),
        .cycle_end_o   (cycle_end_w)
    );

    bus_capture u_bus_capture (
        .clk_logic_w   (clk_logic_w),
        .arst_n_i      (arst_n_i),
        .cycle_start_i (cycle_start_w),
        .cycle_end_i   (cycle_end_w),
        .addr_i        (a2_addr_i),
        .rw_n_i        (a2_rw_n_i),
        .data_i        (a2_data_i),
        .addr_o        (addr_w),
        .rw_n_o        (rw_n_w),
        .bus_valid_o   (bus_valid_w),
        .rd_stb_o      (rd_stb_w),
        .wr_stb_o      (wr_stb_w),
        .wr_data_o     (wr_data_w)
    );

    // Mockingboard-style interval timer
    timer_card #(
        .SLOT (TIMER_SLOT)
    ) u_timer_card (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .cycle_end_i (cycle_end_w),
        .bus_valid_i (bus_valid_w),
        .addr_i      (addr_w),
        .rw_n_i      (rw_n_w),
        .wr_stb_i    (wr_stb_w),
        .wr_data_i   (wr_data_w),
        .rd_en_o     (timer_rd_en_w),
        .rd_data_o   (timer_rd_data_w),
        .irq_n_o     (timer_irq_n_w)
    );

    // SuperSerial-style transmitter
    serial_card #(
        .SLOT     (SERIAL_SLOT),
        .BAUD_DIV (BAUD_DIV)
    ) u_serial_card (
        .clk_logic_w (clk_logic_w),
        .arst_n_i    (arst_n_i),
        .rd_stb_i    (rd_stb_w),
        .bus_valid_i (bus_valid_w),
        .addr_i      (addr_w),
        .rw_n_i      (rw_n_w),
        .wr_stb_i    (wr_stb_w),
        .wr_data_i   (wr_data_w),
        .rd_en_o     (serial_rd_en_w),
        .rd_data_o   (serial_rd_data_w),
        .irq_n_o     (serial_irq_n_w),
        .uart_tx_o   (uart_tx_o)
    );

    bus_arbiter u_bus_arbiter (
        .clk_logic_w      (clk_logic_w),
        .arst_n_i         (arst_n_i),
        .bus_valid_i      (bus_valid_w),
        .serial_rd_en_i   (serial_rd_en_w),
        .serial_rd_data_i (serial_rd_data_w),
        .timer_rd_en_i    (timer_rd_en_w),
        .timer_rd_data_i  (timer_rd_data_w),
        .serial_irq_n_i   (serial_irq_n_w),
        .timer_irq_n_i    (timer_irq_n_w),
        .data_o           (a2_data_o),
        .data_oe_o        (a2_data_oe_o),
        .irq_n_o          (a2_irq_n_o)
    );

endmodule

// File: src/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                           clk_logic_w,
    input  logic                           arst_n_i,
    input  logic                           bus_valid_i,
    input  logic                           serial_rd_en_i,
    input  logic [a2_card_pkg::DATA_W-1:0] serial_rd_data_i,
    input  logic                           timer_rd_en_i,
    input  logic [a2_card_pkg::DATA_W-1:0] timer_rd_data_i,
    input  logic                           serial_irq_n_i,
    input  logic                           timer_irq_n_i,
    output logic [a2_card_pkg::DATA_W-1:0] data_o,
    output logic                           data_oe_o,
    output logic                           irq_n_o
);
    import a2_card_pkg::*;

    logic              any_rd_en;
    logic [DATA_W-1:0] grant_data;

    assign any_rd_en  = bus_valid_i && (serial_rd_en_i || timer_rd_en_i);
    // Serial card wins if both respond
    assign grant_data = serial_rd_en_i ? serial_rd_data_i : timer_rd_data_i;

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_o    <= '0;
            data_oe_o <= 1'b0;
            irq_n_o   <= 1'b1;
        end else begin
            data_oe_o <= any_rd_en;
            // Sample once per cycle so read side effects do not change the byte
            if (any_rd_en && !data_oe_o) begin
                data_o <= grant_data;
            end
            // Open-collector style wired-AND of the card IRQs
            irq_n_o <= serial_irq_n_i && timer_irq_n_i;
        end
    end

endmodule

// File: src/bus_capture.sv
`timescale 1ns/1ps

module bus_capture (
    input  logic                           clk_logic_w,
    input  logic                           arst_n_i,
    input  logic                           cycle_start_i,
    input  logic                           cycle_end_i,
    input  logic [a2_card_pkg::ADDR_W-1:0] addr_i,
    input  logic                           rw_n_i,
    input  logic [a2_card_pkg::DATA_W-1:0] data_i,
    output a2_card_pkg::a2_addr_u          addr_o,
    output logic                           rw_n_o,
    output logic                           bus_valid_o,
    output logic                           rd_stb_o,
    output logic                           wr_stb_o,
    output logic [a2_card_pkg::DATA_W-1:0] wr_data_o
);
    import a2_card_pkg::*;

    // Address and direction are held for the whole bus cycle
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            addr_o      <= '0;
            rw_n_o      <= 1'b1;
            bus_valid_o <= 1'b0;
            rd_stb_o    <= 1'b0;
            wr_stb_o    <= 1'b0;
        end else begin
            rd_stb_o <= cycle_start_i && rw_n_i;
            // Only a cycle that was started can complete a write
            wr_stb_o <= cycle_end_i && bus_valid_o && !rw_n_o;
            if (cycle_start_i) begin
                addr_o.raw  <= addr_i;
                rw_n_o      <= rw_n_i;
                bus_valid_o <= 1'b1;
            end else if (cycle_end_i) begin
                bus_valid_o <= 1'b0;
            end
        end
    end

    // CPU write data is only settled late in Phi0
    always_ff @(posedge clk_logic_w) begin
        if (cycle_end_i) begin
            wr_data_o <= data_i;
        end
    end

endmodule

// File: src/phi_sync.sv
`timescale 1ns/1ps

module phi_sync (
    input  logic clk_logic_w,
    input  logic arst_n_i,
    input  logic phi1_i,
    output logic cycle_start_o,
    output logic cycle_end_o
);

    logic phi1_meta_q;
    logic phi1_sync_q;
    logic phi1_prev_q;

    // Two-flop synchroniser, then one stage of history for edge detection
    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            phi1_meta_q   <= 1'b1;
            phi1_sync_q   <= 1'b1;
            phi1_prev_q   <= 1'b1;
            cycle_start_o <= 1'b0;
            cycle_end_o   <= 1'b0;
        end else begin
            phi1_meta_q <= phi1_i;
            phi1_sync_q <= phi1_meta_q;
            phi1_prev_q <= phi1_sync_q;
            // Phi1 falling means Phi0 begins
            cycle_start_o <= phi1_prev_q && !phi1_sync_q;
            // Phi1 rising closes the Phi0 half
            cycle_end_o   <= !phi1_prev_q && phi1_sync_q;
        end
    end

endmodule

// File: src/serial_card.sv
`timescale 1ns/1ps

module serial_card #(
    parameter int SLOT     = 2,
    parameter int BAUD_DIV = 16
) (
    input  logic                           clk_logic_w,
    input  logic                           arst_n_i,
    input  logic                           rd_stb_i,
    input  logic                           bus_valid_i,
    input  a2_card_pkg::a2_addr_u          addr_i,
    input  logic                           rw_n_i,
    input  logic                           wr_stb_i,
    input  logic [a2_card_pkg::DATA_W-1:0] wr_data_i,
    output logic                           rd_en_o,
    output logic [a2_card_pkg::DATA_W-1:0] rd_data_o,
    output logic                           irq_n_o,
    output logic                           uart_tx_o
);
    import a2_card_pkg::*;

    localparam int CNT_W    = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
    // Bit index of the stop bit, start bit is index 0
    localparam int LAST_BIT = DATA_W + 1;

    logic             sel;
    logic [REG_W-1:0] reg_idx;
    logic             start;
    logic             baud_tick;
    logic [CNT_W-1:0] baud_cnt_q;
    logic [3:0]       bit_cnt_q;
    logic [DATA_W:0]  shift_q;
    logic [DATA_W-1:0] tx_data_q;
    logic             busy_q;
    logic             done_q;
    logic             irq_en_q;

    assign sel = (addr_i.io.page == IO_PAGE) && addr_i.io.devsel
                 && (addr_i.io.slot == SLOT_W'(SLOT));
    assign reg_idx   = addr_i.io.reg_idx;
    assign rd_en_o   = bus_valid_i && rw_n_i && sel;
    assign irq_n_o   = !(done_q && irq_en_q);
    // Writes while busy are dropped
    assign start     = wr_stb_i && sel && (reg_idx == SER_REG_DATA) && !busy_q;
    assign baud_tick = (baud_cnt_q == CNT_W'(BAUD_DIV - 1));

    always_comb begin
        case (reg_idx)
            SER_REG_DATA: rd_data_o = tx_data_q;
            SER_REG_STAT: rd_data_o = {{(DATA_W-2){1'b0}}, done_q, busy_q};
            default:      rd_data_o = '0;
        endcase
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            baud_cnt_q <= '0;
            bit_cnt_q  <= '0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
            irq_en_q   <= 1'b0;
            uart_tx_o  <= 1'b1;
        end else begin
            if (wr_stb_i && sel && (reg_idx == SER_REG_CTRL)) begin
                irq_en_q <= wr_data_i[0];
            end
            // Status read acknowledges the done flag
            if (rd_stb_i && sel && (reg_idx == SER_REG_STAT)) begin
                done_q <= 1'b0;
            end
            if (start) begin
                busy_q     <= 1'b1;
                uart_tx_o  <= 1'b0;
                baud_cnt_q <= '0;
                bit_cnt_q  <= '0;
            end else if (busy_q) begin
                if (!baud_tick) begin
                    baud_cnt_q <= baud_cnt_q + 1'b1;
                end else begin
                    baud_cnt_q <= '0;
                    if (bit_cnt_q == 4'(LAST_BIT)) begin
                        busy_q <= 1'b0;
                        done_q <= 1'b1;
                    end else begin
                        uart_tx_o <= shift_q[0];
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
            end
        end
    end

    // Data bits LSB first, stop bit sits above them
    always_ff @(posedge clk_logic_w) begin
        if (start) begin
            shift_q   <= {1'b1, wr_data_i};
            tx_data_q <= wr_data_i;
        end else if (busy_q && baud_tick && (bit_cnt_q != 4'(LAST_BIT))) begin
            shift_q <= {1'b1, shift_q[DATA_W:1]};
        end
    end

endmodule

// File: src/timer_card.sv
`timescale 1ns/1ps

module timer_card #(
    parameter int SLOT = 4
) (
    input  logic                           clk_logic_w,
    input  logic                           arst_n_i,
    input  logic                           cycle_end_i,
    input  logic                           bus_valid_i,
    input  a2_card_pkg::a2_addr_u          addr_i,
    input  logic                           rw_n_i,
    input  logic                           wr_stb_i,
    input  logic [a2_card_pkg::DATA_W-1:0] wr_data_i,
    output logic                           rd_en_o,
    output logic [a2_card_pkg::DATA_W-1:0] rd_data_o,
    output logic                           irq_n_o
);
    import a2_card_pkg::*;

    logic                sel;
    logic [REG_W-1:0]    reg_idx;
    logic [2*DATA_W-1:0] latch_q;
    logic [2*DATA_W-1:0] count_q;
    logic                running_q;
    logic                irq_en_q;
    logic                flag_q;

    assign sel = (addr_i.io.page == IO_PAGE) && addr_i.io.devsel
                 && (addr_i.io.slot == SLOT_W'(SLOT));
    assign reg_idx = addr_i.io.reg_idx;
    assign rd_en_o = bus_valid_i && rw_n_i && sel;
    assign irq_n_o = !(flag_q && irq_en_q);

    always_comb begin
        case (reg_idx)
            TMR_REG_LO:   rd_data_o = count_q[DATA_W-1:0];
            TMR_REG_HI:   rd_data_o = count_q[2*DATA_W-1:DATA_W];
            TMR_REG_CTRL: rd_data_o = {{(DATA_W-1){1'b0}}, irq_en_q};
            TMR_REG_STAT: rd_data_o = {{(DATA_W-1){1'b0}}, flag_q};
            default:      rd_data_o = '0;
        endcase
    end

    always_ff @(posedge clk_logic_w or negedge arst_n_i) begin
        if (!arst_n_i) begin
            latch_q   <= '0;
            count_q   <= '0;
            running_q <= 1'b0;
            irq_en_q  <= 1'b0;
            flag_q    <= 1'b0;
        end else begin
            // One tick per bus cycle, reload on underflow like the 6522 T1
            if (running_q && cycle_end_i) begin
                if (count_q == '0) begin
                    count_q <= latch_q;
                    flag_q  <= 1'b1;
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end
            if (wr_stb_i && sel) begin
                case (reg_idx)
                    TMR_REG_LO: latch_q[DATA_W-1:0] <= wr_data_i;
                    // High byte write arms the timer
                    TMR_REG_HI: begin
                        latch_q[2*DATA_W-1:DATA_W] <= wr_data_i;
                        count_q   <= {wr_data_i, latch_q[DATA_W-1:0]};
                        running_q <= 1'b1;
                    end
                    TMR_REG_CTRL: irq_en_q <= wr_data_i[0];
                    TMR_REG_STAT: flag_q <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

endmodule
